/* mem_pkg.sv */
// shared types and constants of the memory subsystem
// RTL and testbench refer to them by scoped names
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // load/store buffer entry tag, the "nick" of the core
    localparam int TAG_W = 4;

    // byte count of one transfer, 1 to 4
    localparam int CNT_W = 3;

    // address bits 17:16 of the uart region
    localparam logic [1:0] IO_SEL = 2'b11;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // access size as it comes from the load/store buffer
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // one little-endian word, seen as byte lanes or as halves
    // byte 0 and half 0 sit in the low bits
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

/* fetch_unit.sv */
// instruction fetch: keeps the pc, asks the memory controller for words
// and hands them downstream in program order, dropping wrong-path words
`timescale 1ns/1ps

module fetch_unit #(
    parameter mem_pkg::addr_t RESET_PC = 32'h0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           rdy,
    input  logic           jump_en,
    input  mem_pkg::addr_t jump_pc,
    input  logic           fetch_stall,
    input  logic           fetch_done,
    input  mem_pkg::word_t fetch_word,
    output logic           fetch_req,
    output mem_pkg::addr_t fetch_addr,
    output logic           inst_en,
    output mem_pkg::word_t inst,
    output mem_pkg::addr_t inst_pc
);

    mem_pkg::addr_t pc_q;
    mem_pkg::addr_t addr_q;
    mem_pkg::addr_t inst_pc_q;
    mem_pkg::word_t inst_q;
    logic           req_q;
    logic           stale_q;
    logic           inst_en_q;
    logic           issue;
    logic           accept;

    // a held word is taken at the same edge, so the slot is free on return
    assign issue  = !req_q && !fetch_stall && !jump_en;
    assign accept = fetch_done && !stale_q && !jump_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q      <= RESET_PC;
            req_q     <= 1'b0;
            stale_q   <= 1'b0;
            inst_en_q <= 1'b0;
        end else if (rdy) begin
            if (inst_en_q && !fetch_stall) begin
                inst_en_q <= 1'b0;
            end
            if (fetch_done) begin
                req_q   <= 1'b0;
                stale_q <= 1'b0;
            end else if (issue) begin
                req_q <= 1'b1;
            end
            if (accept) begin
                inst_en_q <= 1'b1;
                pc_q      <= addr_q + 32'd4;
            end
            // redirect flushes the held word and spoils the one in flight
            if (jump_en) begin
                pc_q      <= jump_pc;
                inst_en_q <= 1'b0;
                if (req_q && !fetch_done) begin
                    stale_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issue) begin
                addr_q <= pc_q;
            end
            if (accept) begin
                inst_q    <= fetch_word;
                inst_pc_q <= addr_q;
            end
        end
    end

    assign fetch_req  = req_q;
    assign fetch_addr = addr_q;
    assign inst_en    = inst_en_q;
    assign inst       = inst_q;
    assign inst_pc    = inst_pc_q;

endmodule

/* data_port.sv */
// data side of the memory controller for the load/store buffer
// holds one request, returns loads extended and tagged
`timescale 1ns/1ps

module data_port (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rdy,
    input  logic               ls_en,
    input  logic               ls_store,
    input  mem_pkg::size_e     ls_size,
    input  logic               ls_unsigned,
    input  mem_pkg::addr_t     ls_addr,
    input  mem_pkg::word_t     ls_wdata,
    input  mem_pkg::tag_t      ls_tag,
    output logic               ls_busy,
    output logic               ls_done,
    output mem_pkg::word_t     ls_rdata,
    output mem_pkg::tag_t      ls_done_tag,
    output logic               dm_req,
    output logic               dm_store,
    output mem_pkg::cnt_t      dm_count,
    output mem_pkg::addr_t     dm_addr,
    output mem_pkg::word_t     dm_wdata,
    input  logic               dm_done,
    input  mem_pkg::mem_word_u dm_word
);

    logic           busy_q;
    logic           req_q;
    logic           done_q;
    logic           store_q;
    logic           unsigned_q;
    mem_pkg::cnt_t  count_q;
    mem_pkg::addr_t addr_q;
    mem_pkg::word_t wdata_q;
    mem_pkg::tag_t  tag_q;
    mem_pkg::word_t rdata_q;
    mem_pkg::tag_t  done_tag_q;
    logic           take;
    mem_pkg::cnt_t  size_count;
    logic           sign_b;
    logic           sign_h;
    mem_pkg::word_t load_val;

    assign take = ls_en && !busy_q;

    // size code to byte count on the bus
    always_comb begin
        case (ls_size)
            mem_pkg::SIZE_BYTE: size_count = 3'd1;
            mem_pkg::SIZE_HALF: size_count = 3'd2;
            default:            size_count = 3'd4;
        endcase
    end

    assign sign_b = !unsigned_q && dm_word.b[0][7];
    assign sign_h = !unsigned_q && dm_word.h[0][15];

    // lb/lbu, lh/lhu and lw
    always_comb begin
        case (count_q)
            3'd1:    load_val = {{24{sign_b}}, dm_word.b[0]};
            3'd2:    load_val = {{16{sign_h}}, dm_word.h[0]};
            default: load_val = dm_word.b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (rdy) begin
            done_q <= dm_done;
            if (take) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
            end else if (dm_done) begin
                busy_q <= 1'b0;
                req_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (take) begin
                store_q    <= ls_store;
                unsigned_q <= ls_unsigned;
                count_q    <= size_count;
                addr_q     <= ls_addr;
                wdata_q    <= ls_wdata;
                tag_q      <= ls_tag;
            end
            if (dm_done) begin
                // stores report back with zero data
                rdata_q    <= store_q ? '0 : load_val;
                done_tag_q <= tag_q;
            end
        end
    end

    assign ls_busy     = busy_q;
    assign ls_done     = done_q;
    assign ls_rdata    = rdata_q;
    assign ls_done_tag = done_tag_q;
    assign dm_req      = req_q;
    assign dm_store    = store_q;
    assign dm_count    = count_q;
    assign dm_addr     = addr_q;
    assign dm_wdata    = wdata_q;

endmodule

/* mem_ctrl.sv */
// memory controller: puts fetch and data requests byte by byte on the
// serial memory bus, data side first, one transfer at a time
`timescale 1ns/1ps

module mem_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rdy,
    input  logic               fetch_req,
    input  mem_pkg::addr_t     fetch_addr,
    output logic               fetch_done,
    output mem_pkg::word_t     fetch_word,
    input  logic               dm_req,
    input  logic               dm_store,
    input  mem_pkg::cnt_t      dm_count,
    input  mem_pkg::addr_t     dm_addr,
    input  mem_pkg::word_t     dm_wdata,
    output logic               dm_done,
    output mem_pkg::mem_word_u dm_word,
    input  logic [7:0]         mem_din,
    output logic [7:0]         mem_dout,
    output mem_pkg::addr_t     mem_a,
    output logic               mem_wr,
    input  logic               io_buffer_full
);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_WAIT, ST_DONE} state_e;

    state_e             state_q;
    logic               own_data_q;
    logic               store_q;
    mem_pkg::cnt_t      cnt_q;
    mem_pkg::cnt_t      idx_q;
    mem_pkg::addr_t     base_q;
    mem_pkg::mem_word_u wdata_q;
    mem_pkg::mem_word_u buf_q;
    logic               iss_rd_q;
    logic [1:0]         iss_lane_q;
    logic               rd_valid_q;
    logic [1:0]         rd_lane_q;
    logic               done_q;
    mem_pkg::addr_t     mem_a_q;
    logic [7:0]         mem_dout_q;
    logic               mem_wr_q;

    logic               take;
    logic               issuing;
    logic               cur_store;
    mem_pkg::cnt_t      cur_cnt;
    mem_pkg::cnt_t      cur_idx;
    mem_pkg::addr_t     cur_addr;
    mem_pkg::mem_word_u cur_wdata;
    mem_pkg::addr_t     iss_addr;
    logic               io_hold;
    logic               iss_last;
    mem_pkg::mem_word_u gathered;

    assign take    = (state_q == ST_IDLE) && (dm_req || fetch_req);
    assign issuing = take || (state_q == ST_BUSY);

    // in idle the new request drives the first byte directly
    always_comb begin
        if (state_q == ST_IDLE) begin
            cur_store = dm_req && dm_store;
            cur_cnt   = dm_req ? dm_count : mem_pkg::cnt_t'(4);
            cur_addr  = dm_req ? dm_addr : fetch_addr;
            cur_wdata = mem_pkg::mem_word_u'(dm_wdata);
            cur_idx   = '0;
        end else begin
            cur_store = store_q;
            cur_cnt   = cnt_q;
            cur_addr  = base_q;
            cur_wdata = wdata_q;
            cur_idx   = idx_q;
        end
    end

    assign iss_addr = cur_addr + mem_pkg::addr_t'(cur_idx);
    assign iss_last = (cur_idx == cur_cnt - mem_pkg::cnt_t'(1));

    // uart writes hold off while its buffer is full
    assign io_hold = cur_store && (iss_addr[17:16] == mem_pkg::IO_SEL) && io_buffer_full;

    // read byte lands one cycle after its address
    always_comb begin
        gathered = buf_q;
        if (rd_valid_q) begin
            gathered.b[rd_lane_q] = mem_din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            own_data_q <= 1'b0;
            idx_q      <= '0;
            iss_rd_q   <= 1'b0;
            rd_valid_q <= 1'b0;
            done_q     <= 1'b0;
            mem_a_q    <= '0;
            mem_wr_q   <= 1'b0;
        end else if (rdy) begin
            rd_valid_q <= iss_rd_q;
            iss_rd_q   <= 1'b0;
            mem_wr_q   <= 1'b0;
            done_q     <= 1'b0;
            if (take) begin
                own_data_q <= dm_req;
            end
            if (issuing) begin
                mem_a_q <= iss_addr;
                if (io_hold) begin
                    idx_q   <= cur_idx;
                    state_q <= ST_BUSY;
                end else begin
                    mem_wr_q <= cur_store;
                    iss_rd_q <= !cur_store;
                    idx_q    <= cur_idx + mem_pkg::cnt_t'(1);
                    if (!iss_last) begin
                        state_q <= ST_BUSY;
                    end else if (cur_store) begin
                        // write done rides along with the last byte
                        state_q <= ST_DONE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= ST_WAIT;
                    end
                end
            end else if (state_q == ST_WAIT) begin
                state_q <= ST_DONE;
                done_q  <= 1'b1;
            end else if (state_q == ST_DONE) begin
                state_q <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (take) begin
                store_q <= cur_store;
                cnt_q   <= cur_cnt;
                base_q  <= cur_addr;
                wdata_q <= cur_wdata;
            end
            if (issuing && !io_hold) begin
                mem_dout_q <= cur_wdata.b[cur_idx[1:0]];
                iss_lane_q <= cur_idx[1:0];
            end
            rd_lane_q <= iss_lane_q;
            if (rd_valid_q) begin
                buf_q <= gathered;
            end
        end
    end

    assign fetch_done = done_q && !own_data_q;
    assign dm_done    = done_q && own_data_q;
    assign fetch_word = gathered.b;
    assign dm_word    = gathered;
    assign mem_a      = mem_a_q;
    assign mem_dout   = mem_dout_q;
    assign mem_wr     = mem_wr_q;

endmodule

/* mem_subsys.sv */
// memory side of the rv32i core: fetch unit and data port sharing
// the byte-wide memory bus through one controller
`timescale 1ns/1ps

module mem_subsys #(
    parameter mem_pkg::addr_t RESET_PC = 32'h0
) (
    input  logic           clk_in,
    input  logic           arst_n,
    input  logic           rdy,

    // instruction stream
    input  logic           jump_en,
    input  mem_pkg::addr_t jump_pc,
    input  logic           fetch_stall,
    output logic           inst_en,
    output mem_pkg::word_t inst,
    output mem_pkg::addr_t inst_pc,

    // load/store buffer
    input  logic           ls_en,
    input  logic           ls_store,
    input  mem_pkg::size_e ls_size,
    input  logic           ls_unsigned,
    input  mem_pkg::addr_t ls_addr,
    input  mem_pkg::word_t ls_wdata,
    input  mem_pkg::tag_t  ls_tag,
    output logic           ls_busy,
    output logic           ls_done,
    output mem_pkg::word_t ls_rdata,
    output mem_pkg::tag_t  ls_done_tag,

    // memory bus
    input  logic [7:0]     mem_din,
    output logic [7:0]     mem_dout,
    output mem_pkg::addr_t mem_a,
    output logic           mem_wr,
    input  logic           io_buffer_full
);

    logic               fetch_req;
    mem_pkg::addr_t     fetch_addr;
    logic               fetch_done;
    mem_pkg::word_t     fetch_word;
    logic               dm_req;
    logic               dm_store;
    mem_pkg::cnt_t      dm_count;
    mem_pkg::addr_t     dm_addr;
    mem_pkg::word_t     dm_wdata;
    logic               dm_done;
    mem_pkg::mem_word_u dm_word;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_i (
        .clk        (clk_in),
        .arst_n     (arst_n),
        .rdy        (rdy),
        .jump_en    (jump_en),
        .jump_pc    (jump_pc),
        .fetch_stall(fetch_stall),
        .fetch_done (fetch_done),
        .fetch_word (fetch_word),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .inst_en    (inst_en),
        .inst       (inst),
        .inst_pc    (inst_pc)
    );

    data_port data_port_i (
        .clk        (clk_in),
        .arst_n     (arst_n),
        .rdy        (rdy),
        .ls_en      (ls_en),
        .ls_store   (ls_store),
        .ls_size    (ls_size),
        .ls_unsigned(ls_unsigned),
        .ls_addr    (ls_addr),
        .ls_wdata   (ls_wdata),
        .ls_tag     (ls_tag),
        .ls_busy    (ls_busy),
        .ls_done    (ls_done),
        .ls_rdata   (ls_rdata),
        .ls_done_tag(ls_done_tag),
        .dm_req     (dm_req),
        .dm_store   (dm_store),
        .dm_count   (dm_count),
        .dm_addr    (dm_addr),
        .dm_wdata   (dm_wdata),
        .dm_done    (dm_done),
        .dm_word    (dm_word)
    );

    mem_ctrl mem_ctrl_i (
        .clk           (clk_in),
        .arst_n        (arst_n),
        .rdy           (rdy),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_done    (fetch_done),
        .fetch_word    (fetch_word),
        .dm_req        (dm_req),
        .dm_store      (dm_store),
        .dm_count      (dm_count),
        .dm_addr       (dm_addr),
        .dm_wdata      (dm_wdata),
        .dm_done       (dm_done),
        .dm_word       (dm_word),
        .mem_din       (mem_din),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .io_buffer_full(io_buffer_full)
    );

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset source
// 20 ns clock, reset held low over the first rising edges
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a rising edge, flops still see reset at that edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* tb_mem_model.sv */
// byte-wide memory model of the testbench: 128 KB, read data one cycle
// after the address, writes on mem_wr, uart region bytes go to a log
`timescale 1ns/1ps

module tb_mem_model (
    input  logic           clk,
    input  mem_pkg::addr_t mem_a,
    input  logic [7:0]     mem_dout,
    input  logic           mem_wr,
    output logic [7:0]     mem_din,
    output int             io_count,
    output logic [7:0]     io_last
);

    // filled by the testbench before the first access
    logic [7:0] mem [0:131071];

    initial begin
        mem_din  = 8'h00;
        io_count = 0;
        io_last  = 8'h00;
    end

    always @(posedge clk) begin
        // old contents on a read of the address being written
        mem_din <= mem[mem_a[16:0]];
        if (mem_wr) begin
            if (mem_a[17:16] == mem_pkg::IO_SEL) begin
                // zero bytes are not printed by the uart
                if (mem_dout != 8'h00) begin
                    io_last  <= mem_dout;
                    io_count <= io_count + 1;
                end
            end else begin
                mem[mem_a[16:0]] = mem_dout;
            end
        end
    end

endmodule

/* tb_mem_subsys.sv */
// testbench of the memory subsystem: applies a table of loads, stores,
// jumps and rdy pauses while the fetch stream is checked on the side
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam mem_pkg::addr_t RESET_PC = 32'h0000_0100;
    localparam int MEM_BYTES = 131072;
    localparam int TIMEOUT   = 200;
    localparam int N_OPS     = 19;
    localparam mem_pkg::size_e SZ_B = mem_pkg::SIZE_BYTE;
    localparam mem_pkg::size_e SZ_H = mem_pkg::SIZE_HALF;
    localparam mem_pkg::size_e SZ_W = mem_pkg::SIZE_WORD;

    typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_JUMP, OP_PAUSE} op_kind_e;

    // pause rows keep their cycle count in wdata
    typedef struct packed {
        op_kind_e       kind;
        mem_pkg::size_e size;
        logic           uns;
        mem_pkg::addr_t addr;
        mem_pkg::word_t wdata;
        mem_pkg::tag_t  tag;
    } op_t;

    logic           clk;
    logic           arst_n;
    logic           rdy;
    logic           jump_en;
    mem_pkg::addr_t jump_pc;
    logic           fetch_stall;
    logic           inst_en;
    mem_pkg::word_t inst;
    mem_pkg::addr_t inst_pc;
    logic           ls_en;
    logic           ls_store;
    mem_pkg::size_e ls_size;
    logic           ls_unsigned;
    mem_pkg::addr_t ls_addr;
    mem_pkg::word_t ls_wdata;
    mem_pkg::tag_t  ls_tag;
    logic           ls_busy;
    logic           ls_done;
    mem_pkg::word_t ls_rdata;
    mem_pkg::tag_t  ls_done_tag;
    logic [7:0]     mem_din;
    logic [7:0]     mem_dout;
    mem_pkg::addr_t mem_a;
    logic           mem_wr;
    logic           io_buffer_full;
    int             io_count;
    logic [7:0]     io_last;

    logic [7:0]     shadow [0:MEM_BYTES-1];
    op_t            ops [N_OPS];
    mem_pkg::addr_t exp_pc = RESET_PC;
    int             inst_count = 0;
    int             access_count = 0;
    int             error_count = 0;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .arst_n(arst_n)
    );

    tb_mem_model mem_model_i (
        .clk     (clk),
        .mem_a   (mem_a),
        .mem_dout(mem_dout),
        .mem_wr  (mem_wr),
        .mem_din (mem_din),
        .io_count(io_count),
        .io_last (io_last)
    );

    mem_subsys #(
        .RESET_PC(RESET_PC)
    ) mem_subsys_i (
        .clk_in        (clk),
        .arst_n        (arst_n),
        .rdy           (rdy),
        .jump_en       (jump_en),
        .jump_pc       (jump_pc),
        .fetch_stall   (fetch_stall),
        .inst_en       (inst_en),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .ls_en         (ls_en),
        .ls_store      (ls_store),
        .ls_size       (ls_size),
        .ls_unsigned   (ls_unsigned),
        .ls_addr       (ls_addr),
        .ls_wdata      (ls_wdata),
        .ls_tag        (ls_tag),
        .ls_busy       (ls_busy),
        .ls_done       (ls_done),
        .ls_rdata      (ls_rdata),
        .ls_done_tag   (ls_done_tag),
        .mem_din       (mem_din),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .io_buffer_full(io_buffer_full)
    );

    function automatic op_t make_op(input op_kind_e kind, input mem_pkg::size_e size,
            input logic uns, input mem_pkg::addr_t addr, input mem_pkg::word_t wdata,
            input mem_pkg::tag_t tag);
        return '{kind, size, uns, addr, wdata, tag};
    endfunction

    function automatic int size_bytes(input mem_pkg::size_e size);
        case (size)
            mem_pkg::SIZE_BYTE: return 1;
            mem_pkg::SIZE_HALF: return 2;
            default:            return 4;
        endcase
    endfunction

    // little-endian bytes from the shadow copy, low byte first
    function automatic mem_pkg::word_t read_shadow(input mem_pkg::addr_t addr, input int n);
        mem_pkg::word_t acc;
        mem_pkg::addr_t a;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + mem_pkg::addr_t'(i);
            acc = acc | (mem_pkg::word_t'(shadow[a[16:0]]) << (8 * i));
        end
        return acc;
    endfunction

    function automatic mem_pkg::word_t expected_load(input mem_pkg::addr_t addr,
            input mem_pkg::size_e size, input logic uns);
        mem_pkg::mem_word_u w;
        w = read_shadow(addr, size_bytes(size));
        case (size)
            mem_pkg::SIZE_BYTE: return uns ? {24'h0, w.b[0]} : {{24{w.b[0][7]}}, w.b[0]};
            mem_pkg::SIZE_HALF: return uns ? {16'h0, w.h[0]} : {{16{w.h[0][15]}}, w.h[0]};
            default:            return w;
        endcase
    endfunction

    task automatic check_inst(input mem_pkg::addr_t got_pc, input mem_pkg::word_t got,
            input mem_pkg::addr_t want_pc, input mem_pkg::word_t want);
        if (got_pc !== want_pc || got !== want) begin
            error_count++;
            $display("Mismatch at %0t: inst %h at pc %h, expected %h at pc %h",
                $time, got, got_pc, want, want_pc);
        end
    endtask

    task automatic check_load(input mem_pkg::word_t got, input mem_pkg::tag_t got_tag,
            input mem_pkg::word_t want, input mem_pkg::tag_t want_tag);
        if (got !== want || got_tag !== want_tag) begin
            error_count++;
            $display("Mismatch at %0t: ls_rdata %h tag %h, expected %h tag %h",
                $time, got, got_tag, want, want_tag);
        end
    endtask

    task automatic check_uart(input int got_count, input logic [7:0] got,
            input int want_count, input logic [7:0] want);
        if (got_count != want_count || got !== want) begin
            error_count++;
            $display("Mismatch at %0t: uart log %0d bytes last %h, expected %0d last %h",
                $time, got_count, got, want_count, want);
        end
    endtask

    task automatic check_bus(input mem_pkg::addr_t got_a, input logic got_wr,
            input mem_pkg::addr_t want_a, input logic want_wr);
        if (got_a !== want_a || got_wr !== want_wr) begin
            error_count++;
            $display("Mismatch at %0t: bus moved while rdy low, mem_a %h mem_wr %b",
                $time, got_a, got_wr);
        end
    endtask

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            error_count++;
            $display("Mismatch at %0t: %s is %b after reset, expected 0", $time, name, got);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_ls_idle();
        int cycles;
        cycles = 0;
        while (ls_busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ls_busy) begin
            abort_run("load/store port stayed busy");
        end
    endtask

    task automatic wait_ls_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ls_done && cycles < TIMEOUT);
        if (!ls_done) begin
            abort_run("no ls_done for the pending load or store");
        end
    endtask

    task automatic wait_insts(input int n);
        int cycles;
        int target;
        cycles = 0;
        target = inst_count + n;
        while (inst_count < target && cycles < TIMEOUT * n) begin
            @(negedge clk);
            cycles++;
        end
        if (inst_count < target) begin
            abort_run("instruction stream stopped");
        end
    endtask

    task automatic run_access(input op_t op);
        mem_pkg::word_t want;
        mem_pkg::addr_t a;
        logic           is_io;
        int             log_before;
        is_io = op.kind == OP_STORE && op.addr[17:16] == mem_pkg::IO_SEL;
        want = (op.kind == OP_STORE) ? '0 : expected_load(op.addr, op.size, op.uns);
        log_before = io_count;
        wait_ls_idle();
        @(posedge clk);
        ls_en       <= 1'b1;
        ls_store    <= op.kind == OP_STORE;
        ls_size     <= op.size;
        ls_unsigned <= op.uns;
        ls_addr     <= op.addr;
        ls_wdata    <= op.wdata;
        ls_tag      <= op.tag;
        if (is_io) begin
            io_buffer_full <= 1'b1;
        end
        @(posedge clk);
        ls_en <= 1'b0;
        if (is_io) begin
            // uart full, the byte has to stay in the controller
            repeat (10) begin
                @(negedge clk);
                if (ls_done || io_count != log_before) begin
                    error_count++;
                    $display("Error at %0t: uart write went through while buffer full", $time);
                end
            end
            @(posedge clk);
            io_buffer_full <= 1'b0;
        end
        wait_ls_done();
        access_count++;
        check_load(ls_rdata, ls_done_tag, want, op.tag);
        if (is_io) begin
            check_uart(io_count, io_last, log_before + 1, op.wdata[7:0]);
        end else if (op.kind == OP_STORE) begin
            for (int i = 0; i < size_bytes(op.size); i++) begin
                a = op.addr + mem_pkg::addr_t'(i);
                shadow[a[16:0]] = 8'(op.wdata >> (8 * i));
            end
        end
    endtask

    task automatic run_jump(input mem_pkg::addr_t target);
        @(posedge clk);
        jump_en <= 1'b1;
        jump_pc <= target;
        @(posedge clk);
        jump_en <= 1'b0;
        wait_insts(2);
    endtask

    task automatic run_pause(input int cycles);
        mem_pkg::addr_t held_a;
        logic           held_wr;
        @(posedge clk);
        rdy <= 1'b0;
        @(negedge clk);
        held_a  = mem_a;
        held_wr = mem_wr;
        repeat (cycles) begin
            @(negedge clk);
            check_bus(mem_a, mem_wr, held_a, held_wr);
        end
        @(posedge clk);
        rdy         <= 1'b1;
        fetch_stall <= 1'b1;
        // downstream back-pressure right after the pause
        repeat (cycles) @(posedge clk);
        fetch_stall <= 1'b0;
    endtask

    // a word counts as taken when it is still shown at the next rising edge
    always @(negedge clk) begin
        if (arst_n && rdy) begin
            if (inst_en && !fetch_stall) begin
                check_inst(inst_pc, inst, exp_pc, read_shadow(exp_pc, 4));
                inst_count++;
                exp_pc = exp_pc + 32'd4;
            end
            if (jump_en) begin
                exp_pc = jump_pc;
            end
        end
    end

    initial begin
        int             cycles;
        mem_pkg::word_t word;
        mem_pkg::addr_t a;
        rdy            = 1'b1;
        jump_en        = 1'b0;
        jump_pc        = '0;
        fetch_stall    = 1'b0;
        ls_en          = 1'b0;
        ls_store       = 1'b0;
        ls_size        = SZ_W;
        ls_unsigned    = 1'b0;
        ls_addr        = '0;
        ls_wdata       = '0;
        ls_tag         = '0;
        io_buffer_full = 1'b0;

        void'($urandom(32'h76b9_3f20));
        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            word = $urandom();
            for (int k = 0; k < 4; k++) begin
                a = mem_pkg::addr_t'(4 * w + k);
                shadow[a[16:0]] = 8'(word >> (8 * k));
                mem_model_i.mem[a[16:0]] = 8'(word >> (8 * k));
            end
        end

        // code lives low, data from 0x8000, uart at 0x30000
        ops[0]  = make_op(OP_STORE, SZ_B, 1'b0, 32'h0000_8000, 32'h0000_0085, 4'd1);
        ops[1]  = make_op(OP_LOAD,  SZ_B, 1'b0, 32'h0000_8000, 32'h0, 4'd2);
        ops[2]  = make_op(OP_LOAD,  SZ_B, 1'b1, 32'h0000_8000, 32'h0, 4'd3);
        ops[3]  = make_op(OP_STORE, SZ_H, 1'b0, 32'h0000_8010, 32'h0000_9a3c, 4'd4);
        ops[4]  = make_op(OP_LOAD,  SZ_H, 1'b0, 32'h0000_8010, 32'h0, 4'd5);
        ops[5]  = make_op(OP_LOAD,  SZ_H, 1'b1, 32'h0000_8010, 32'h0, 4'd6);
        ops[6]  = make_op(OP_JUMP,  SZ_W, 1'b0, 32'h0000_0400, 32'h0, 4'd0);
        ops[7]  = make_op(OP_STORE, SZ_W, 1'b0, 32'h0000_8020, 32'hdead_beef, 4'd7);
        ops[8]  = make_op(OP_LOAD,  SZ_W, 1'b0, 32'h0000_8020, 32'h0, 4'd8);
        ops[9]  = make_op(OP_LOAD,  SZ_B, 1'b0, 32'h0000_8023, 32'h0, 4'd9);
        ops[10] = make_op(OP_PAUSE, SZ_W, 1'b0, 32'h0, 32'd5, 4'd0);
        ops[11] = make_op(OP_LOAD,  SZ_H, 1'b0, 32'h0000_8041, 32'h0, 4'd10);
        ops[12] = make_op(OP_STORE, SZ_H, 1'b0, 32'h0000_8030, 32'h0000_1234, 4'd11);
        ops[13] = make_op(OP_LOAD,  SZ_H, 1'b0, 32'h0000_8030, 32'h0, 4'd12);
        ops[14] = make_op(OP_STORE, SZ_B, 1'b0, 32'h0003_0000, 32'h0000_0041, 4'd13);
        ops[15] = make_op(OP_JUMP,  SZ_W, 1'b0, 32'h0000_0200, 32'h0, 4'd0);
        ops[16] = make_op(OP_LOAD,  SZ_W, 1'b0, 32'h0000_8101, 32'h0, 4'd14);
        ops[17] = make_op(OP_LOAD,  SZ_B, 1'b1, 32'h0000_8104, 32'h0, 4'd15);
        ops[18] = make_op(OP_PAUSE, SZ_W, 1'b0, 32'h0, 32'd3, 4'd0);

        cycles = 0;
        while (!arst_n && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!arst_n) begin
            abort_run("reset was never released");
        end
        check_low("inst_en", inst_en);
        check_low("ls_done", ls_done);
        check_low("ls_busy", ls_busy);
        check_low("mem_wr", mem_wr);

        wait_insts(4);
        for (int k = 0; k < N_OPS; k++) begin
            case (ops[k].kind)
                OP_LOAD, OP_STORE: run_access(ops[k]);
                OP_JUMP:           run_jump(ops[k].addr);
                default:           run_pause(int'(ops[k].wdata));
            endcase
        end
        wait_insts(3);
        if (inst_count < 20) begin
            error_count++;
            $display("Error at %0t: only %0d instructions delivered", $time, inst_count);
        end

        $display("%0d instructions, %0d loads/stores checked, %0d errors",
            inst_count, access_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
mem_pkg.sv
fetch_unit.sv
data_port.sv
mem_ctrl.sv
mem_subsys.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_mem_subsys.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vtb_mem_subsys: files.f $(wildcard *.sv)
	verilator --binary --timing --top-module tb_mem_subsys -f files.f

run: obj_dir/Vtb_mem_subsys
	@out="$$(./obj_dir/Vtb_mem_subsys)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
